//--- Makefile
VERILATOR = verilator
TOP       = cacheTb
FILELIST  = project.f
OBJDIR    = obj_dir
VFLAGS    = --binary --timing --timescale 1ns/100ps --top-module $(TOP) --Mdir $(OBJDIR)
SIM       = $(OBJDIR)/V$(TOP)
SOURCES   = $(wildcard source/*.sv source/*.svh dv/*.sv)

.PHONY: compile run clean

compile: $(SIM)

$(SIM): $(FILELIST) $(SOURCES)
	$(VERILATOR) $(VFLAGS) -f $(FILELIST)

run: $(SIM)
	./$(SIM)

clean:
	rm -rf $(OBJDIR)

//--- dv/busMemory.sv
// Line-wide memory behind the cache bus
// Acks each request a fixed 3 cycles after it appears, ack lasts one cycle
// Every word starts as its word address XOR 32'hdc16_517c, reloaded on reset
// peekAdr/peekLine give a zero-time backdoor read of a whole line
`timescale 1ns/100ps
`default_nettype none
`include "cache_cfg.svh"

module busMemory
  import cachePkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic [1:0] cacheBusRw,        // [1] fetch, [0] writeback
  input  adrT        cacheBusAdr,
  input  lineT       cacheBusWriteData,
  output logic       cacheBusAck,
  output lineT       fetchBuffer,       // Holds the last fetched line
  input  adrT        peekAdr,
  output lineT       peekLine
);
  localparam int Latency    = 3;
  localparam int LineIdxLen = `CACHE_PA_BITS - OffsetLen;
  localparam int NumLines   = 2 ** LineIdxLen;

  lineT                  lineMem [NumLines];
  logic [1:0]            waitCnt;   // Cycles the current request has waited
  logic [LineIdxLen-1:0] busIdx;

  assign busIdx   = cacheBusAdr[`CACHE_PA_BITS-1:OffsetLen];
  assign peekLine = lineMem[peekAdr[`CACHE_PA_BITS-1:OffsetLen]];

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      // Known pattern over the whole address space
      for (int l = 0; l < NumLines; l++) begin
        for (int w = 0; w < WordsPerLine; w++) begin
          lineMem[l][w*`CACHE_WORD_LEN +: `CACHE_WORD_LEN] <=
            wordT'(l * WordsPerLine + w) ^ 32'hdc16_517c;
        end
      end
      waitCnt     <= '0;
      cacheBusAck <= 1'b0;
      fetchBuffer <= '0;
    end else if (cacheBusAck) begin
      cacheBusAck <= 1'b0;     // Cache drops its request now
      waitCnt     <= '0;
    end else if (|cacheBusRw) begin
      if (waitCnt == 2'(Latency - 1)) begin
        cacheBusAck <= 1'b1;
        if (cacheBusRw[0]) lineMem[busIdx] <= cacheBusWriteData;
        if (cacheBusRw[1]) fetchBuffer <= lineMem[busIdx];  // Valid in the ack cycle
      end else begin
        waitCnt <= waitCnt + 2'd1;
      end
    end
  end
endmodule

`default_nettype wire

//--- dv/cacheTb.sv
// Testbench for the two-way data cache
// A table of CPU operations is built against a shadow memory, then replayed
// Inputs change 1 ns after the rising edge, outputs are sampled on the falling edge
// Stops at the first mismatch; the run is bounded at 200 cycles per entry
`timescale 1ns/100ps
`default_nettype none
`include "cache_cfg.svh"

module cacheTb
  import cachePkg::*;
();
  localparam int   ResetCycles = 16;
  localparam int   NumWords    = 2 ** (`CACHE_PA_BITS - ByteOffLen);
  localparam wordT MemPattern  = 32'hdc16_517c;

  typedef enum logic [2:0] {opRead, opWrite, opFlush, opInvalidate, opCheckMem} opT;

  typedef struct packed {
    opT       op;
    adrT      adr;
    byteMaskT mask;
    wordT     data;
    wordT     expWord;   // Read result
    lineT     expLine;   // Backdoor line for memory checks
    logic     expMiss;
  } entryT;

  logic       clk;
  logic       rstN;
  logic [1:0] cacheRw;
  logic       flushCache;
  logic       invalidateCache;
  adrT        pAdr;
  byteMaskT   byteMask;
  wordT       cacheWriteData;
  wordT       readDataWord;
  logic       cacheStall;
  logic       cacheMiss;
  logic       cacheAccess;
  logic [1:0] cacheBusRw;
  adrT        cacheBusAdr;
  lineT       cacheBusWriteData;
  logic       cacheBusAck;
  lineT       fetchBuffer;
  adrT        peekAdr;
  lineT       peekLine;

  wordT  shadowMem [NumWords];   // What the CPU should see
  entryT entries[$];
  int    cycleLimit;

  cache uut (.*);
  busMemory mem (.*);

  initial begin
    clk = 1'b0;
    forever #4 clk = ~clk;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Table building, expected values come from the shadow memory
  ////////////////////////////////////////////////////////////////////////////
  task automatic readAt(adrT adr, logic expMiss);
    entryT e;
    e = '0;
    e.op      = opRead;
    e.adr     = adr;
    e.mask    = '1;
    e.expWord = shadowMem[adr[`CACHE_PA_BITS-1:ByteOffLen]];
    e.expMiss = expMiss;
    entries.push_back(e);
  endtask

  task automatic writeAt(adrT adr, byteMaskT mask, wordT data, logic expMiss);
    entryT e;
    e = '0;
    e.op      = opWrite;
    e.adr     = adr;
    e.mask    = mask;
    e.data    = data;
    e.expMiss = expMiss;
    for (int b = 0; b < WordBytes; b++) begin
      if (mask[b]) shadowMem[adr[`CACHE_PA_BITS-1:ByteOffLen]][8*b +: 8] = data[8*b +: 8];
    end
    entries.push_back(e);
  endtask

  task automatic controlOp(opT op);
    entryT e;
    e = '0;
    e.op = op;     // Flush or invalidate, never a miss
    entries.push_back(e);
  endtask

  task automatic expectMemLine(adrT adr);
    entryT e;
    int    lineBase;
    e = '0;
    e.op     = opCheckMem;
    e.adr    = adr;
    lineBase = int'(adr[`CACHE_PA_BITS-1:OffsetLen]) * WordsPerLine;
    for (int w = 0; w < WordsPerLine; w++) begin
      e.expLine[w*`CACHE_WORD_LEN +: `CACHE_WORD_LEN] = shadowMem[lineBase + w];
    end
    entries.push_back(e);
  endtask

  task automatic checkValue(string name, lineT actual, lineT expected);
    if (actual !== expected) begin
      $display("[ERROR] %0t ns: %s is %0h, expected %0h", $time, name, actual, expected);
      $display("test failed");
      $fatal(1);
    end
  endtask

  // One entry: drive, check the first-cycle pulses, wait for the stall to drop
  task automatic applyEntry(entryT e);
    logic isAccess;
    isAccess = (e.op == opRead) || (e.op == opWrite);
    @(posedge clk);
    #1;
    cacheRw         = {e.op == opRead, e.op == opWrite};
    flushCache      = (e.op == opFlush);
    invalidateCache = (e.op == opInvalidate);
    pAdr            = e.adr;
    byteMask        = e.mask;
    cacheWriteData  = e.data;
    peekAdr         = e.adr;
    @(negedge clk);
    if (e.op == opCheckMem) begin
      checkValue("peekLine", peekLine, e.expLine);
    end else begin
      checkValue("cacheMiss", lineT'(cacheMiss), lineT'(e.expMiss));
      checkValue("cacheAccess", lineT'(cacheAccess), lineT'(isAccess));
      // Hits and invalidate never stall, a miss or a flush always does
      checkValue("cacheStall", lineT'(cacheStall), lineT'(e.expMiss | (e.op == opFlush)));
      while (cacheStall) @(negedge clk);     // Held until the request is done
      if (e.op == opRead) checkValue("readDataWord", lineT'(readDataWord), lineT'(e.expWord));
    end
  endtask

  ////////////////////////////////////////////////////////////////////////////
  // Stimulus
  ////////////////////////////////////////////////////////////////////////////
  initial begin : stimulus
    rstN            = 1'b0;
    cacheRw         = 2'b00;
    flushCache      = 1'b0;
    invalidateCache = 1'b0;
    pAdr            = '0;
    byteMask        = '0;
    cacheWriteData  = '0;
    peekAdr         = '0;
    for (int i = 0; i < NumWords; i++) shadowMem[i] = wordT'(i) ^ MemPattern;

    readAt(16'h0104, 1'b1);                            // Cold miss, set 0
    readAt(16'h0108, 1'b0);                            // Same line hits
    writeAt(16'h010c, 4'b0101, 32'ha5a5_5a5a, 1'b0);   // Write hit
    readAt(16'h010c, 1'b0);
    writeAt(16'h0454, 4'b1100, 32'h1234_5678, 1'b1);   // Write miss merges into fill
    readAt(16'h0454, 1'b0);
    // Set 2 with A 0x0120, B 0x0220, C 0x0320
    readAt(16'h0120, 1'b1);
    writeAt(16'h0224, 4'b1111, 32'hdead_beef, 1'b1);   // B dirty
    readAt(16'h0128, 1'b0);                            // A again, B now LRU
    readAt(16'h0320, 1'b1);                            // C evicts dirty B
    expectMemLine(16'h0220);
    readAt(16'h0120, 1'b0);
    readAt(16'h0224, 1'b1);
    writeAt(16'h0128, 4'b0011, 32'h0bad_f00d, 1'b0);
    controlOp(opFlush);
    expectMemLine(16'h0100);
    expectMemLine(16'h0120);
    expectMemLine(16'h0220);
    expectMemLine(16'h0450);
    readAt(16'h010c, 1'b0);                            // Flush keeps lines valid
    readAt(16'h0454, 1'b0);
    readAt(16'h0128, 1'b0);
    controlOp(opInvalidate);
    readAt(16'h010c, 1'b1);                            // Refetch of flushed data
    readAt(16'h0454, 1'b1);
    readAt(16'h0128, 1'b1);
    cycleLimit = ResetCycles + 200 * entries.size();

    repeat (ResetCycles) @(posedge clk);
    #1 rstN = 1'b1;
    for (int i = 0; i < entries.size(); i++) applyEntry(entries[i]);
    @(posedge clk);
    #1 cacheRw = 2'b00;
    $display("test passed");
    $finish;
  end

  initial begin : watchdog
    int cycles;
    cycles = 0;
    @(posedge clk);
    while (cycles < cycleLimit) begin
      @(posedge clk);
      cycles++;
    end
    $display("Run hung, no completion within %0d cycles", cycleLimit);
    $display("test failed");
    $fatal(1);
  end
endmodule

`default_nettype wire

//--- project.f
+incdir+source
source/cachePkg.sv
source/cacheCtrlIf.sv
source/cacheWays.sv
source/cacheLru.sv
source/cacheDatapath.sv
source/cacheFsm.sv
source/cache.sv
dv/busMemory.sv
dv/cacheTb.sv

//--- source/cache.sv
// Two-way write-back data cache, top level
// One CPU word access at a time, whole-line bus transfers
// Bus write data is the line read from the selected way
`timescale 1ns/100ps
`default_nettype none

module cache
  import cachePkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  // CPU side
  input  logic [1:0] cacheRw,            // [1] read, [0] write
  input  logic       flushCache,
  input  logic       invalidateCache,
  input  adrT        pAdr,
  input  byteMaskT   byteMask,
  input  wordT       cacheWriteData,
  output wordT       readDataWord,
  output logic       cacheStall,
  output logic       cacheMiss,          // Performance counter pulses
  output logic       cacheAccess,
  // Bus side
  output logic [1:0] cacheBusRw,         // [1] fetch, [0] writeback
  output adrT        cacheBusAdr,
  output lineT       cacheBusWriteData,
  input  logic       cacheBusAck,
  input  lineT       fetchBuffer
);
  setT      cacheSet;
  lineT     lineWriteData;
  lineMaskT lineByteMask;
  wayVecT   hitWay;
  wayVecT   validWay;
  wayVecT   victimWay;
  wayVecT   flushWay;
  tagT      tag;

  cacheCtrlIf ctrl ();

  cacheFsm uFsm (.clk, .rstN, .cacheRw, .flushCache, .invalidateCache, .cacheBusAck,
    .ctrl(ctrl.fsm), .cacheBusRw, .cacheStall, .cacheMiss, .cacheAccess);

  // Selected way line feeds both the word mux and the bus
  cacheWays uWays (.clk, .rstN, .ctrl(ctrl.ways), .invalidateCache, .cacheSet, .pAdr,
    .lineWriteData, .lineByteMask, .victimWay, .flushWay, .hitWay, .validWay,
    .readDataLine(cacheBusWriteData), .tag);

  cacheLru uLru (.clk, .rstN, .ctrl(ctrl.ways), .invalidateCache, .cacheSet, .hitWay,
    .validWay, .victimWay);

  cacheDatapath uDatapath (.clk, .rstN, .ctrl(ctrl.datapath), .pAdr, .byteMask,
    .cacheWriteData, .fetchBuffer, .readDataLine(cacheBusWriteData), .tag, .cacheSet,
    .flushWay, .lineWriteData, .lineByteMask, .readDataWord, .cacheBusAdr);
endmodule

`default_nettype wire

//--- source/cacheCtrlIf.sv
// Control strobes and status flags between the FSM and the datapath blocks
// Plain wires, no clock inside
`timescale 1ns/100ps
`default_nettype none

interface cacheCtrlIf;
  logic cacheEn;        // Array access enable
  logic setValid;       // Fetched line written into victim way
  logic clearValid;
  logic setDirty;       // Store data written
  logic clearDirty;
  logic selWriteback;   // Victim way drives read line and tag
  logic selFlush;       // Flush counters drive set and way
  logic selFetchBuffer; // Return word straight from the fetch buffer
  logic lruWriteEn;
  logic flushAdrCntEn;
  logic flushWayCntEn;
  logic flushCntRst;
  logic cacheHit;
  logic lineDirty;      // Victim or flush way holds dirty data
  logic flushAdrFlag;   // Last set reached
  logic flushWayFlag;   // Last way reached

  modport fsm (
    output cacheEn, setValid, clearValid, setDirty, clearDirty, selWriteback, selFlush,
           selFetchBuffer, lruWriteEn, flushAdrCntEn, flushWayCntEn, flushCntRst,
    input  cacheHit, lineDirty, flushAdrFlag, flushWayFlag
  );
  // Shared by the arrays and the LRU block
  modport ways (
    input  cacheEn, setValid, clearValid, setDirty, clearDirty, selWriteback, selFlush,
           lruWriteEn,
    output cacheHit, lineDirty
  );
  modport datapath (
    input  setValid, setDirty, selWriteback, selFlush, selFetchBuffer,
           flushAdrCntEn, flushWayCntEn, flushCntRst,
    output flushAdrFlag, flushWayFlag
  );
endinterface

`default_nettype wire

//--- source/cacheDatapath.sv
// Address muxes, flush counters, store merge and word select
// Bus addresses are always line aligned
`timescale 1ns/100ps
`default_nettype none
`include "cache_cfg.svh"

module cacheDatapath
  import cachePkg::*;
(
  input  logic         clk,
  input  logic         rstN,
  cacheCtrlIf.datapath ctrl,
  input  adrT          pAdr,
  input  byteMaskT     byteMask,
  input  wordT         cacheWriteData,
  input  lineT         fetchBuffer,
  input  lineT         readDataLine,
  input  tagT          tag,
  output setT          cacheSet,
  output wayVecT       flushWay,
  output lineT         lineWriteData,
  output lineMaskT     lineByteMask,
  output wordT         readDataWord,
  output adrT          cacheBusAdr
);
  localparam int WordIdxLen = $clog2(WordsPerLine);
  localparam int WayIdxLen  = $clog2(`CACHE_NUM_WAYS);

  setT                   pSet;
  setT                   flushAdr;
  logic [WordIdxLen-1:0] wordIdx;
  logic [WayIdxLen-1:0]  flushWayIdx;
  lineMaskT              demuxedMask;   // Word byte mask placed in its line slot
  lineMaskT              fetchByteSel;  // 1 keeps the fetched byte
  lineT                  readLine;

  assign pSet     = pAdr[OffsetLen +: SetLen];
  assign wordIdx  = pAdr[ByteOffLen +: WordIdxLen];
  assign cacheSet = ctrl.selFlush ? flushAdr : pSet;

  ////////////////////////////////////////////////////////////////////////////
  // Flush walk
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) begin
      flushAdr    <= '0;
      flushWayIdx <= '0;
    end else if (ctrl.flushCntRst) begin
      flushAdr    <= '0;
      flushWayIdx <= '0;
    end else begin
      if (ctrl.flushAdrCntEn) flushAdr <= flushAdr + 1'b1;
      if (ctrl.flushWayCntEn) flushWayIdx <= flushWayIdx + 1'b1;  // Wraps to way 0
    end
  end

  assign flushWay          = wayVecT'(1) << flushWayIdx;
  assign ctrl.flushAdrFlag = (flushAdr == setT'(`CACHE_NUM_LINES - 1));
  assign ctrl.flushWayFlag = (flushWayIdx == WayIdxLen'(`CACHE_NUM_WAYS - 1));

  ////////////////////////////////////////////////////////////////////////////
  // Write path
  ////////////////////////////////////////////////////////////////////////////
  always_comb begin
    for (int w = 0; w < WordsPerLine; w++) begin
      demuxedMask[w*WordBytes +: WordBytes] = (wordIdx == WordIdxLen'(w)) ? byteMask : '0;
    end
  end

  // Load fill keeps the whole fetched line; a store replaces its masked bytes
  assign fetchByteSel = (ctrl.setValid & ~ctrl.setDirty) ? '1 : ~demuxedMask;
  assign lineByteMask = ctrl.setValid ? '1 : (ctrl.setDirty ? demuxedMask : '0);

  always_comb begin
    for (int b = 0; b < LineBytes; b++) begin
      lineWriteData[8*b +: 8] = fetchByteSel[b] ? fetchBuffer[8*b +: 8]
                                                : cacheWriteData[8*(b % WordBytes) +: 8];
    end
  end

  // Read path, fetch buffer bypass saves a cycle on a miss
  assign readLine     = ctrl.selFetchBuffer ? fetchBuffer : readDataLine;
  assign readDataWord = readLine[wordIdx*`CACHE_WORD_LEN +: `CACHE_WORD_LEN];

  always_comb begin
    if (ctrl.selFlush) cacheBusAdr = {tag, flushAdr, {OffsetLen{1'b0}}};
    else if (ctrl.selWriteback) cacheBusAdr = {tag, pSet, {OffsetLen{1'b0}}};  // Victim line
    else cacheBusAdr = {pAdr[`CACHE_PA_BITS-1:OffsetLen], {OffsetLen{1'b0}}};  // Fetch
  end
endmodule

`default_nettype wire

//--- source/cacheFsm.sv
// Cache controller
// Bus request is a state decode, so it stays up through the ack cycle
// and drops on the next one; the FSM waits on the ack indefinitely
// Flush assumes no CPU request is presented while flushCache is high
`timescale 1ns/100ps
`default_nettype none

module cacheFsm
  import cachePkg::*;
(
  input  logic       clk,
  input  logic       rstN,
  input  logic [1:0] cacheRw,          // [1] read, [0] write
  input  logic       flushCache,
  input  logic       invalidateCache,
  input  logic       cacheBusAck,
  cacheCtrlIf.fsm    ctrl,
  output logic [1:0] cacheBusRw,       // [1] line fetch, [0] line writeback
  output logic       cacheStall,
  output logic       cacheMiss,
  output logic       cacheAccess
);
  cacheStateT state;
  cacheStateT nextState;
  logic       isReady;
  logic       anyReq;
  logic       anyMiss;
  logic       anyHit;
  logic       flushLast;  // Last set and last way
  logic       flushStep;  // Current flush entry is done

  assign isReady   = (state == ready);
  assign anyReq    = (|cacheRw) & ~invalidateCache;  // Invalidate takes the cycle
  assign anyMiss   = anyReq & ~ctrl.cacheHit;
  assign anyHit    = anyReq & ctrl.cacheHit;
  assign flushLast = ctrl.flushAdrFlag & ctrl.flushWayFlag;
  assign flushStep = ((state == flushCheck) & ~ctrl.lineDirty) |
                     ((state == flushWriteback) & cacheBusAck);

  ////////////////////////////////////////////////////////////////////////////
  // State register and next state
  ////////////////////////////////////////////////////////////////////////////
  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) state <= ready;
    else state <= nextState;
  end

  always_comb begin
    nextState = state;
    case (state)
      ready: begin
        if (anyMiss & ctrl.lineDirty) nextState = writeback;
        else if (anyMiss) nextState = fetch;
        else if (flushCache) nextState = flushCheck;
      end
      writeback: if (cacheBusAck) nextState = fetch;
      fetch: if (cacheBusAck) nextState = writeLine;
      writeLine: nextState = ready;       // Request completes here
      flushCheck: begin
        if (ctrl.lineDirty) nextState = flushWriteback;
        else if (flushLast) nextState = flushDone;
      end
      flushWriteback: begin
        if (cacheBusAck) nextState = flushLast ? flushDone : flushCheck;
      end
      flushDone: nextState = ready;
      default: nextState = ready;
    endcase
  end

  ////////////////////////////////////////////////////////////////////////////
  // Array and datapath strobes
  ////////////////////////////////////////////////////////////////////////////
  assign ctrl.cacheEn        = ~isReady | anyReq | flushCache;
  assign ctrl.setValid       = (state == writeLine);
  assign ctrl.setDirty       = ((isReady & anyHit) | (state == writeLine)) & cacheRw[0];
  assign ctrl.clearValid     = (state == writeback) & cacheBusAck;  // Victim gone until refill
  assign ctrl.clearDirty     = ((state == writeback) | (state == flushWriteback)) & cacheBusAck;
  assign ctrl.selWriteback   = (state == writeback);
  assign ctrl.selFlush       = (state == flushCheck) | (state == flushWriteback);
  assign ctrl.selFetchBuffer = (state == writeLine);
  assign ctrl.lruWriteEn     = (isReady & anyHit) | (state == writeLine);
  assign ctrl.flushWayCntEn  = flushStep;
  assign ctrl.flushAdrCntEn  = flushStep & ctrl.flushWayFlag;  // Next set after last way
  assign ctrl.flushCntRst    = flushStep & flushLast;

  // CPU and bus side
  assign cacheBusRw  = {state == fetch, (state == writeback) | (state == flushWriteback)};
  assign cacheStall  = (isReady & (anyMiss | flushCache)) |
                       (state == writeback) | (state == fetch) |
                       (state == flushCheck) | (state == flushWriteback);
  assign cacheMiss   = isReady & anyMiss;   // Ready only in a request's first cycle
  assign cacheAccess = isReady & anyReq;
endmodule

`default_nettype wire

//--- source/cacheLru.sv
// Victim choice for a two-way cache, one LRU bit per set
// An invalid way is always taken first, lowest index wins
`timescale 1ns/100ps
`default_nettype none
`include "cache_cfg.svh"

module cacheLru
  import cachePkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  cacheCtrlIf.ways ctrl,
  input  logic     invalidateCache,
  input  setT      cacheSet,
  input  wayVecT   hitWay,
  input  wayVecT   validWay,
  output wayVecT   victimWay
);
  logic [`CACHE_NUM_LINES-1:0] lruBits;  // Set bit means way 1 is least recently used
  wayVecT usedWay;

  always_comb begin
    if (!validWay[0]) victimWay = 2'b01;
    else if (!validWay[1]) victimWay = 2'b10;
    else if (lruBits[cacheSet]) victimWay = 2'b10;
    else victimWay = 2'b01;
  end

  assign usedWay = ctrl.setValid ? victimWay : hitWay;  // A fill counts as a use

  always_ff @(posedge clk or negedge rstN) begin
    if (!rstN) lruBits <= '0;
    else if (invalidateCache) lruBits <= '0;
    else if (ctrl.cacheEn & ctrl.lruWriteEn & (|usedWay))
      lruBits[cacheSet] <= usedWay[0];  // Other way becomes LRU
  end
endmodule

`default_nettype wire

//--- source/cachePkg.sv
// Shared types for the data cache
// Derived widths follow from the geometry in the cfg header
`default_nettype none

package cachePkg;
  `include "cache_cfg.svh"

  localparam int LineBytes    = `CACHE_LINE_LEN / 8;
  localparam int WordBytes    = `CACHE_WORD_LEN / 8;
  localparam int OffsetLen    = $clog2(LineBytes);        // Byte offset within a line
  localparam int ByteOffLen   = $clog2(WordBytes);        // Byte offset within a word
  localparam int SetLen       = $clog2(`CACHE_NUM_LINES);
  localparam int TagLen       = `CACHE_PA_BITS - SetLen - OffsetLen;
  localparam int WordsPerLine = `CACHE_LINE_LEN / `CACHE_WORD_LEN;

  typedef logic [`CACHE_PA_BITS-1:0]  adrT;
  typedef logic [`CACHE_LINE_LEN-1:0] lineT;
  typedef logic [`CACHE_WORD_LEN-1:0] wordT;
  typedef logic [WordBytes-1:0]       byteMaskT;
  typedef logic [LineBytes-1:0]       lineMaskT;
  typedef logic [SetLen-1:0]          setT;
  typedef logic [TagLen-1:0]          tagT;
  typedef logic [`CACHE_NUM_WAYS-1:0] wayVecT;     // One bit per way, one-hot

  // Controller states
  typedef enum logic [2:0] {
    ready,
    writeback,       // Dirty victim going out before a fetch
    fetch,
    writeLine,       // Fetched line lands in the array
    flushCheck,
    flushWriteback,
    flushDone
  } cacheStateT;
endpackage

`default_nettype wire

//--- source/cacheWays.sv
// Tag, valid, dirty and data storage for all ways
// Flip-flop arrays with combinational read, so a hit resolves in one cycle
// Invalidate drops every line at once, dirty or not
`timescale 1ns/100ps
`default_nettype none
`include "cache_cfg.svh"

module cacheWays
  import cachePkg::*;
(
  input  logic     clk,
  input  logic     rstN,
  cacheCtrlIf.ways ctrl,
  input  logic     invalidateCache,
  input  setT      cacheSet,
  input  adrT      pAdr,
  input  lineT     lineWriteData,
  input  lineMaskT lineByteMask,
  input  wayVecT   victimWay,
  input  wayVecT   flushWay,
  output wayVecT   hitWay,
  output wayVecT   validWay,
  output lineT     readDataLine,
  output tagT      tag
);
  localparam int NumWays  = `CACHE_NUM_WAYS;
  localparam int NumLines = `CACHE_NUM_LINES;

  tagT    pTag;
  wayVecT selWay;             // Way read, written or updated this cycle
  wayVecT dirtyWay;
  lineT   lineWay [NumWays];  // Per-way line, zero unless selected
  tagT    tagWay  [NumWays];

  assign pTag = pAdr[`CACHE_PA_BITS-1 -: TagLen];

  // Flush walk wins, then a fill or writeback uses the victim, else the hit way
  always_comb begin
    if (ctrl.selFlush) selWay = flushWay;
    else if (ctrl.selWriteback | ctrl.setValid) selWay = victimWay;
    else selWay = hitWay;
  end

  ////////////////////////////////////////////////////////////////////////////
  // Per-way storage
  ////////////////////////////////////////////////////////////////////////////
  for (genvar w = 0; w < NumWays; w++) begin : gWay
    tagT                 tagMem  [NumLines];
    lineT                dataMem [NumLines];
    logic [NumLines-1:0] validBits;
    logic [NumLines-1:0] dirtyBits;

    assign validWay[w] = validBits[cacheSet];
    assign hitWay[w]   = validBits[cacheSet] & (tagMem[cacheSet] == pTag);
    // Dirty status looks at the eviction candidate, never the hit way
    assign dirtyWay[w] = (ctrl.selFlush ? flushWay[w] : victimWay[w]) &
                         validBits[cacheSet] & dirtyBits[cacheSet];
    assign lineWay[w]  = selWay[w] ? dataMem[cacheSet] : '0;  // AND half of the mux
    assign tagWay[w]   = selWay[w] ? tagMem[cacheSet] : '0;

    always_ff @(posedge clk or negedge rstN) begin
      if (!rstN) begin
        validBits <= '0;
        dirtyBits <= '0;
      end else if (invalidateCache) begin
        validBits <= '0;
        dirtyBits <= '0;
      end else if (ctrl.cacheEn & selWay[w]) begin
        if (ctrl.setValid) validBits[cacheSet] <= 1'b1;
        else if (ctrl.clearValid) validBits[cacheSet] <= 1'b0;
        if (ctrl.setDirty) dirtyBits[cacheSet] <= 1'b1;
        else if (ctrl.clearDirty | ctrl.setValid) dirtyBits[cacheSet] <= 1'b0;  // Clean fill
      end
    end

    always_ff @(posedge clk) begin
      if (ctrl.cacheEn & selWay[w] & ctrl.setValid) tagMem[cacheSet] <= pTag;
      if (ctrl.cacheEn & selWay[w] & (ctrl.setValid | ctrl.setDirty)) begin
        for (int b = 0; b < LineBytes; b++) begin
          if (lineByteMask[b]) dataMem[cacheSet][8*b +: 8] <= lineWriteData[8*b +: 8];
        end
      end
    end
  end

  // OR half of the AND-OR mux
  always_comb begin
    readDataLine = '0;
    tag          = '0;
    for (int w = 0; w < NumWays; w++) begin
      readDataLine = readDataLine | lineWay[w];
      tag          = tag | tagWay[w];
    end
  end

  assign ctrl.cacheHit  = |hitWay;
  assign ctrl.lineDirty = |dirtyWay;
endmodule

`default_nettype wire

//--- source/cache_cfg.svh
// Geometry of the two-way data cache
// Sizes must be powers of two, and a line must hold a whole number of words
// The LRU logic covers exactly two ways
`ifndef CACHE_CFG_SVH
`define CACHE_CFG_SVH

`define CACHE_PA_BITS   16   // Physical address width
`define CACHE_LINE_LEN  128  // Bits per line, moved as one bus transfer
`define CACHE_WORD_LEN  32   // Bits per CPU word
`define CACHE_NUM_LINES 8    // Sets per way
`define CACHE_NUM_WAYS  2    // Two ways only

`endif
